// File: rtl/mlp_geom_pkg.sv
// geometry constants, layer shapes, counter widths and the layer enum
package mlp_geom_pkg;

    localparam int UNIT_NUM    = 4;
    localparam int ARRAY_NUM   = 3;
    localparam int SLICE_WORDS = 8;
    localparam int FETCH_BEATS = UNIT_NUM * UNIT_NUM;
    localparam int BASE_PASSES = 2;
    localparam int LAYER_NUM   = 3;

    localparam int WORD_W  = 64;
    localparam int LANE_W  = 2;
    localparam int LANES   = 32;
    localparam int ADDR_W  = 14;
    localparam int SADDR_W = 12;

    localparam logic [ADDR_W-1:0] BASE_STEP = 14'd2;
    localparam logic [ADDR_W-1:0] BASE_LAST = ADDR_W'(2 * (BASE_PASSES - 1));

    // weight shape per layer, in slices
    localparam logic [7:0] ROW_MAX_L0 = 8'd2;
    localparam logic [7:0] COL_MAX_L0 = 8'd2;
    localparam logic [7:0] ROW_MAX_L1 = 8'd2;
    localparam logic [7:0] COL_MAX_L1 = 8'd3;
    localparam logic [7:0] ROW_MAX_L2 = 8'd3;
    localparam logic [7:0] COL_MAX_L2 = 8'd2;

    localparam int SLICE_CNT_W = $clog2(SLICE_WORDS);
    localparam int FETCH_CNT_W = $clog2(FETCH_BEATS);
    localparam int UNIT_CNT_W  = $clog2(UNIT_NUM);

    localparam logic [SLICE_CNT_W-1:0] SLICE_LAST = SLICE_CNT_W'(SLICE_WORDS - 1);
    localparam logic [FETCH_CNT_W-1:0] FETCH_LAST = FETCH_CNT_W'(FETCH_BEATS - 1);
    localparam logic [UNIT_CNT_W-1:0]  UNIT_LAST  = UNIT_CNT_W'(UNIT_NUM - 1);

    typedef enum logic [1:0] {
        LAYER_PROJ = 2'd0,
        LAYER_FC1  = 2'd1,
        LAYER_FC2  = 2'd2,
        LAYER_END  = 2'(LAYER_NUM)
    } layer_e;

endpackage

// File: rtl/mlp_bus_pkg.sv
// spike word union and the structs passed between controller blocks
package mlp_bus_pkg;

    // raw RAM word or 32 two-bit spike counts
    typedef union packed {
        logic [mlp_geom_pkg::WORD_W-1:0]                           raw;
        logic [mlp_geom_pkg::LANES-1:0][mlp_geom_pkg::LANE_W-1:0] lane;
    } spike_word_u;

    typedef struct packed {
        mlp_geom_pkg::layer_e            layer;
        logic [7:0]                      row_max;
        logic [7:0]                      col_max;
        logic [mlp_geom_pkg::ADDR_W-1:0] base;
    } layer_cfg_s;

    typedef struct packed {
        logic        valid;
        logic        done;
        spike_word_u data;
    } slice_beat_s;

    typedef struct packed {
        logic                             we;
        logic [mlp_geom_pkg::SADDR_W-1:0] addr;
        spike_word_u                      data;
    } ram_wr_s;

    typedef struct packed {
        logic [mlp_geom_pkg::UNIT_NUM-1:0] grant;
        logic                              valid;
    } psum_fetch_s;

endpackage

// File: rtl/mlp_layer_cfg.sv
// layer counter, column counter, read base address and layer shape registers
`timescale 1ns/1ps
module mlp_layer_cfg (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    i_fetch_last,
    output mlp_bus_pkg::layer_cfg_s o_cfg
);
    mlp_geom_pkg::layer_e            layer;
    logic [7:0]                      col_cnt;
    logic [7:0]                      row_max;
    logic [7:0]                      col_max;
    logic [mlp_geom_pkg::ADDR_W-1:0] base;
    logic                            col_wrap;

    assign col_wrap = i_fetch_last && (col_cnt == col_max - 8'd1);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            col_cnt <= '0;
            base    <= '0;
            layer   <= mlp_geom_pkg::LAYER_PROJ;
        end else if (i_fetch_last) begin
            col_cnt <= col_wrap ? 8'd0 : col_cnt + 8'd1;
            if (col_wrap && base == mlp_geom_pkg::BASE_LAST) begin
                base  <= '0;
                layer <= mlp_geom_pkg::layer_e'(layer + 2'd1);
            end else if (col_wrap) begin
                base <= base + mlp_geom_pkg::BASE_STEP;
            end
        end
    end

    // shape follows the layer one cycle later
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            row_max <= mlp_geom_pkg::ROW_MAX_L0;
            col_max <= mlp_geom_pkg::COL_MAX_L0;
        end else begin
            case (layer)
                mlp_geom_pkg::LAYER_PROJ: begin
                    row_max <= mlp_geom_pkg::ROW_MAX_L0;
                    col_max <= mlp_geom_pkg::COL_MAX_L0;
                end
                mlp_geom_pkg::LAYER_FC1: begin
                    row_max <= mlp_geom_pkg::ROW_MAX_L1;
                    col_max <= mlp_geom_pkg::COL_MAX_L1;
                end
                mlp_geom_pkg::LAYER_FC2: begin
                    row_max <= mlp_geom_pkg::ROW_MAX_L2;
                    col_max <= mlp_geom_pkg::COL_MAX_L2;
                end
                default: begin
                    row_max <= 8'hff;
                    col_max <= 8'hff;
                end
            endcase
        end
    end

    assign o_cfg.layer   = layer;
    assign o_cfg.row_max = row_max;
    assign o_cfg.col_max = col_max;
    assign o_cfg.base    = base;

endmodule

// File: rtl/mlp_seq_fsm.sv
// controller FSM for idle, init, compute and fetch, with prepare and done strobes
`timescale 1ns/1ps
module mlp_seq_fsm (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    i_start,
    input  mlp_bus_pkg::layer_cfg_s i_cfg,
    input  logic                    i_rows_last,
    input  logic                    i_fetch_last,
    output logic                    o_init_pulse,
    output logic                    o_cal_active,
    output logic                    o_fetch_active,
    output logic                    o_init_prepare,
    output logic                    o_mlp_done
);
    typedef enum logic [1:0] {S_IDLE, S_INIT, S_CAL, S_FETCH} state_e;

    state_e state;
    state_e state_nxt;
    logic   run_end;

    assign run_end = i_cfg.layer == mlp_geom_pkg::LAYER_END;

    always_comb begin
        case (state)
            S_IDLE:  state_nxt = i_start ? S_INIT : S_IDLE;
            S_INIT:  state_nxt = run_end ? S_IDLE : S_CAL;
            S_CAL:   state_nxt = i_rows_last ? S_FETCH : S_CAL;
            S_FETCH: state_nxt = i_fetch_last ? S_INIT : S_FETCH;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state          <= S_IDLE;
            o_init_prepare <= 1'b0;
            o_mlp_done     <= 1'b0;
        end else begin
            state          <= state_nxt;
            // arrays are prepared only for a real compute round
            o_init_prepare <= (state == S_INIT) && !run_end;
            o_mlp_done     <= (state == S_INIT) && run_end;
        end
    end

    assign o_init_pulse   = state == S_INIT;
    assign o_cal_active   = state == S_CAL;
    assign o_fetch_active = state == S_FETCH;

endmodule

// File: rtl/slice_reader.sv
// slice read addressing, beat pipeline, residual lane add and residual RAM write
`timescale 1ns/1ps
module slice_reader (
    input  logic                                s_clk,
    input  logic                                s_rst,
    input  mlp_bus_pkg::layer_cfg_s             i_cfg,
    input  logic                                i_init_pulse,
    input  logic                                i_cal_active,
    input  logic                                i_slice_ready,
    output logic                                o_rows_last,
    output logic [mlp_geom_pkg::SADDR_W-1:0]    o_ram00_addrb,
    output logic [mlp_geom_pkg::ADDR_W-1:0]     o_ram01_addrb,
    output logic [mlp_geom_pkg::SADDR_W-1:0]    o_ram02_addrb,
    input  mlp_bus_pkg::spike_word_u            i_ram00_doutb,
    input  mlp_bus_pkg::spike_word_u            i_ram01_doutb,
    input  mlp_bus_pkg::spike_word_u            i_ram02_doutb,
    output mlp_bus_pkg::ram_wr_s                o_ram03_wr,
    output mlp_bus_pkg::slice_beat_s            o_beat
);
    logic [mlp_geom_pkg::ADDR_W-1:0]           rd_addr;
    logic [mlp_geom_pkg::SLICE_CNT_W-1:0]      word_cnt;
    logic [7:0]                                row_cnt;
    logic                                      issue;
    logic                                      last_word;
    logic                                      start;
    logic                                      is_fc1;
    logic [1:0]                                v_pipe;
    logic [1:0]                                d_pipe;
    logic [1:0][mlp_geom_pkg::SADDR_W-1:0]     a_pipe;
    mlp_bus_pkg::spike_word_u                  r00;
    mlp_bus_pkg::spike_word_u                  r01;
    mlp_bus_pkg::spike_word_u                  r02;
    mlp_bus_pkg::spike_word_u                  sum_word;
    mlp_bus_pkg::spike_word_u                  beat_data;
    logic                                      beat_v;
    logic                                      beat_done;
    logic                                      wr_we;
    logic [mlp_geom_pkg::SADDR_W-1:0]          wr_addr;

    assign is_fc1    = i_cfg.layer == mlp_geom_pkg::LAYER_FC1;
    assign last_word = word_cnt == mlp_geom_pkg::SLICE_LAST;
    // ready is looked at only here, never mid-slice
    assign start     = i_cal_active && i_slice_ready && !issue && !(|v_pipe) && !beat_v;
    assign o_rows_last = issue && last_word && (row_cnt == i_cfg.row_max - 8'd1);

    assign o_ram00_addrb = is_fc1 ? rd_addr[mlp_geom_pkg::SADDR_W-1:0] : '0;
    assign o_ram02_addrb = is_fc1 ? rd_addr[mlp_geom_pkg::SADDR_W-1:0] : '0;
    assign o_ram01_addrb = is_fc1 ? '0 : rd_addr;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            issue    <= 1'b0;
            word_cnt <= '0;
            row_cnt  <= '0;
            rd_addr  <= '0;
        end else begin
            if (issue && last_word)
                issue <= 1'b0;
            else if (start)
                issue <= 1'b1;
            if (issue)
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            if (issue && last_word)
                row_cnt <= o_rows_last ? 8'd0 : row_cnt + 8'd1;
            // two adjacent words, then jump to the next 8-word group
            if (i_init_pulse)
                rd_addr <= i_cfg.base;
            else if (issue)
                rd_addr <= rd_addr + {{(mlp_geom_pkg::ADDR_W-3){1'b0}},
                                      (word_cnt[0] ? 3'd7 : 3'd1)};
        end
    end

    // lane-wise residual sum, wraps modulo 4
    always_comb begin
        for (int i = 0; i < mlp_geom_pkg::LANES; i++) begin
            sum_word.lane[i] = r00.lane[i] + r02.lane[i];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            v_pipe    <= '0;
            d_pipe    <= '0;
            beat_v    <= 1'b0;
            beat_done <= 1'b0;
            wr_we     <= 1'b0;
        end else begin
            v_pipe    <= {v_pipe[0], issue};
            d_pipe    <= {d_pipe[0], issue && last_word};
            beat_v    <= v_pipe[1];
            beat_done <= d_pipe[1];
            wr_we     <= v_pipe[1] && is_fc1;
        end
    end

    always_ff @(posedge s_clk) begin
        a_pipe    <= {a_pipe[0], rd_addr[mlp_geom_pkg::SADDR_W-1:0]};
        wr_addr   <= a_pipe[1];
        r00       <= i_ram00_doutb;
        r01       <= i_ram01_doutb;
        r02       <= i_ram02_doutb;
        beat_data <= is_fc1 ? sum_word : r01;
    end

    assign o_beat.valid    = beat_v;
    assign o_beat.done     = beat_done;
    assign o_beat.data     = beat_data;
    assign o_ram03_wr.we   = wr_we;
    assign o_ram03_wr.addr = wr_addr;
    assign o_ram03_wr.data = beat_data;

endmodule

// File: rtl/slice_arbiter.sv
// rotating slice grant over the systolic arrays, beat steering and ready select
`timescale 1ns/1ps
module slice_arbiter (
    input  logic                                 s_clk,
    input  logic                                 s_rst,
    input  logic                                 i_idle,
    input  mlp_bus_pkg::slice_beat_s             i_beat,
    input  logic [mlp_geom_pkg::ARRAY_NUM-1:0]   i_ready,
    output logic                                 o_slice_ready,
    output mlp_bus_pkg::slice_beat_s             o_beat_ch0,
    output mlp_bus_pkg::slice_beat_s             o_beat_ch1,
    output mlp_bus_pkg::slice_beat_s             o_beat_ch2
);
    logic [mlp_geom_pkg::ARRAY_NUM-1:0] grant;

    // one-hot, moves on after each finished slice
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            grant <= 3'b001;
        else if (i_idle)
            grant <= 3'b001;
        else if (i_beat.valid && i_beat.done)
            grant <= {grant[1:0], grant[2]};
    end

    assign o_slice_ready = |(grant & i_ready);

    assign o_beat_ch0 = grant[0] ? i_beat : '0;
    assign o_beat_ch1 = grant[1] ? i_beat : '0;
    assign o_beat_ch2 = grant[2] ? i_beat : '0;

endmodule

// File: rtl/psum_fetcher.sv
// array finish tracking and the lane-by-lane partial-sum fetch sweep
`timescale 1ns/1ps
module psum_fetcher (
    input  logic                                s_clk,
    input  logic                                s_rst,
    input  logic                                i_fetch_active,
    input  logic [mlp_geom_pkg::ARRAY_NUM-1:0]  i_finish_calc,
    output mlp_bus_pkg::psum_fetch_s            o_psum,
    output logic                                o_fetch_last
);
    logic [mlp_geom_pkg::ARRAY_NUM-1:0]   fin_flags;
    logic                                 sweep_v;
    logic [mlp_geom_pkg::FETCH_CNT_W-1:0] beat_cnt;
    logic [mlp_geom_pkg::UNIT_NUM-1:0]    lane_gnt;
    logic                                 launch;

    // all arrays finished since the last sweep
    assign launch       = i_fetch_active && (&fin_flags) && !sweep_v;
    assign o_fetch_last = sweep_v && (beat_cnt == mlp_geom_pkg::FETCH_LAST);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            fin_flags <= '0;
            sweep_v   <= 1'b0;
            beat_cnt  <= '0;
            lane_gnt  <= '0;
        end else begin
            fin_flags <= launch ? '0 : (fin_flags | i_finish_calc);
            if (launch) begin
                sweep_v  <= 1'b1;
                beat_cnt <= '0;
                lane_gnt <= {{(mlp_geom_pkg::UNIT_NUM-1){1'b0}}, 1'b1};
            end else if (sweep_v) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (o_fetch_last) begin
                    sweep_v  <= 1'b0;
                    lane_gnt <= '0;
                end else if (beat_cnt[mlp_geom_pkg::UNIT_CNT_W-1:0] == mlp_geom_pkg::UNIT_LAST) begin
                    lane_gnt <= {lane_gnt[mlp_geom_pkg::UNIT_NUM-2:0],
                                 lane_gnt[mlp_geom_pkg::UNIT_NUM-1]};
                end
            end
        end
    end

    assign o_psum.grant = lane_gnt;
    assign o_psum.valid = sweep_v;

endmodule

// File: rtl/mlp_top.sv
// MLP linear controller top: config, FSM, slice reader, arbiter and psum fetcher
`timescale 1ns/1ps
module mlp_top (
    input  logic                                s_clk,
    input  logic                                s_rst,
    input  logic                                i_start,
    output logic [mlp_geom_pkg::SADDR_W-1:0]    o_ram00_addrb,
    output logic [mlp_geom_pkg::ADDR_W-1:0]     o_ram01_addrb,
    output logic [mlp_geom_pkg::SADDR_W-1:0]    o_ram02_addrb,
    input  mlp_bus_pkg::spike_word_u            i_ram00_doutb,
    input  mlp_bus_pkg::spike_word_u            i_ram01_doutb,
    input  mlp_bus_pkg::spike_word_u            i_ram02_doutb,
    output mlp_bus_pkg::ram_wr_s                o_ram03_wr,
    output mlp_bus_pkg::slice_beat_s            o_beat_ch0,
    output mlp_bus_pkg::slice_beat_s            o_beat_ch1,
    output mlp_bus_pkg::slice_beat_s            o_beat_ch2,
    input  logic [mlp_geom_pkg::ARRAY_NUM-1:0]  i_slice_ready,
    input  logic [mlp_geom_pkg::ARRAY_NUM-1:0]  i_finish_calc,
    output mlp_bus_pkg::psum_fetch_s            o_psum,
    output logic                                o_init_prepare,
    output logic                                o_mlp_done
);
    mlp_bus_pkg::layer_cfg_s  cfg;
    mlp_bus_pkg::slice_beat_s beat;
    logic                     init_pulse;
    logic                     cal_active;
    logic                     fetch_active;
    logic                     rows_last;
    logic                     fetch_last;
    logic                     slice_ready;

    mlp_layer_cfg mlp_layer_cfg_inst (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_fetch_last (fetch_last),
        .o_cfg        (cfg)
    );

    mlp_seq_fsm mlp_seq_fsm_inst (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_start        (i_start),
        .i_cfg          (cfg),
        .i_rows_last    (rows_last),
        .i_fetch_last   (fetch_last),
        .o_init_pulse   (init_pulse),
        .o_cal_active   (cal_active),
        .o_fetch_active (fetch_active),
        .o_init_prepare (o_init_prepare),
        .o_mlp_done     (o_mlp_done)
    );

    slice_reader slice_reader_inst (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_cfg         (cfg),
        .i_init_pulse  (init_pulse),
        .i_cal_active  (cal_active),
        .i_slice_ready (slice_ready),
        .o_rows_last   (rows_last),
        .o_ram00_addrb (o_ram00_addrb),
        .o_ram01_addrb (o_ram01_addrb),
        .o_ram02_addrb (o_ram02_addrb),
        .i_ram00_doutb (i_ram00_doutb),
        .i_ram01_doutb (i_ram01_doutb),
        .i_ram02_doutb (i_ram02_doutb),
        .o_ram03_wr    (o_ram03_wr),
        .o_beat        (beat)
    );

    // grant resets to array 0 whenever the controller is idle
    slice_arbiter slice_arbiter_inst (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_idle        (!(cal_active || fetch_active)),
        .i_beat        (beat),
        .i_ready       (i_slice_ready),
        .o_slice_ready (slice_ready),
        .o_beat_ch0    (o_beat_ch0),
        .o_beat_ch1    (o_beat_ch1),
        .o_beat_ch2    (o_beat_ch2)
    );

    psum_fetcher psum_fetcher_inst (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_fetch_active (fetch_active),
        .i_finish_calc  (i_finish_calc),
        .o_psum         (o_psum),
        .o_fetch_last   (fetch_last)
    );

endmodule

// File: sim/tb_mlp_top.sv
// testbench for mlp_top: clock, reset, RAM and array models, scoreboard and directed tests
`timescale 1ns/1ps
module tb_mlp_top;
    logic                     s_clk;
    logic                     s_rst;
    logic                     i_start;
    logic [2:0]               i_slice_ready;
    logic [2:0]               i_finish_calc;
    logic [11:0]              ram00_addr;
    logic [13:0]              ram01_addr;
    logic [11:0]              ram02_addr;
    mlp_bus_pkg::spike_word_u ram00_dout;
    mlp_bus_pkg::spike_word_u ram01_dout;
    mlp_bus_pkg::spike_word_u ram02_dout;
    mlp_bus_pkg::ram_wr_s     ram03_wr;
    mlp_bus_pkg::slice_beat_s beat0;
    mlp_bus_pkg::slice_beat_s beat1;
    mlp_bus_pkg::slice_beat_s beat2;
    mlp_bus_pkg::psum_fetch_s psum;
    logic                     init_prepare;
    logic                     mlp_done;

    logic [63:0] mem00 [4096];
    logic [63:0] mem01 [16384];
    logic [63:0] mem02 [4096];
    logic [63:0] mem03 [4096];
    logic [11:0] addr00_q;
    logic [13:0] addr01_q;
    logic [11:0] addr02_q;
    logic [2:0]  rdy_hist [4];
    int          rdy_wait [3];
    int          fin_wait [3];
    bit          fin_sent [3];
    int          layer_rounds [4];
    int          cyc;
    int          fin_all_at;
    int          lay;
    int          col;
    int          pass;
    int          beat_k;
    int          slice_w;
    int          slice_n;
    int          exp_ch;
    int          sweep_n;
    int          ram03_writes;
    int          done_cnt;
    bit          round_open;
    bit          fetch_phase;

    mlp_top mlp_top_inst (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_start        (i_start),
        .o_ram00_addrb  (ram00_addr),
        .o_ram01_addrb  (ram01_addr),
        .o_ram02_addrb  (ram02_addr),
        .i_ram00_doutb  (ram00_dout),
        .i_ram01_doutb  (ram01_dout),
        .i_ram02_doutb  (ram02_dout),
        .o_ram03_wr     (ram03_wr),
        .o_beat_ch0     (beat0),
        .o_beat_ch1     (beat1),
        .o_beat_ch2     (beat2),
        .i_slice_ready  (i_slice_ready),
        .i_finish_calc  (i_finish_calc),
        .o_psum         (psum),
        .o_init_prepare (init_prepare),
        .o_mlp_done     (mlp_done)
    );

    always #10 s_clk = ~s_clk;

    function automatic int rows_of(input int l);
        case (l)
            0: return int'(mlp_geom_pkg::ROW_MAX_L0);
            1: return int'(mlp_geom_pkg::ROW_MAX_L1);
            2: return int'(mlp_geom_pkg::ROW_MAX_L2);
            default: return 0;
        endcase
    endfunction

    function automatic int cols_of(input int l);
        case (l)
            0: return int'(mlp_geom_pkg::COL_MAX_L0);
            1: return int'(mlp_geom_pkg::COL_MAX_L1);
            default: return int'(mlp_geom_pkg::COL_MAX_L2);
        endcase
    endfunction

    // 32 two-bit counts added lane by lane, carries dropped
    function automatic logic [63:0] lane_add(input logic [63:0] a, input logic [63:0] b);
        logic [63:0] s;
        for (int i = 0; i < 32; i++)
            s[2*i +: 2] = a[2*i +: 2] + b[2*i +: 2];
        return s;
    endfunction

    function automatic mlp_bus_pkg::slice_beat_s beat_on(input int ch);
        case (ch)
            0: return beat0;
            1: return beat1;
            default: return beat2;
        endcase
    endfunction

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic watch_round();
        if (init_prepare) begin
            check_eq(round_open, 0, "prepare strobe while a round is open");
            check_eq(lay < mlp_geom_pkg::LAYER_NUM, 1, "prepare strobe after the last layer");
            round_open = 1'b1;
            beat_k = 0;
            slice_w = 0;
            slice_n = 0;
            exp_ch = 0;
            layer_rounds[lay]++;
        end
        if (mlp_done) begin
            done_cnt++;
            check_eq(round_open, 0, "done strobe inside a round");
            check_eq(lay, 3, "done strobe before the last layer ended");
        end
    endtask

    task automatic watch_beats();
        mlp_bus_pkg::slice_beat_s b;
        logic [63:0]              exp_data;
        int                       addr;
        b = beat_on(exp_ch);
        if (!(beat0.valid || beat1.valid || beat2.valid)) begin
            check_eq(slice_w, 0, "slice stopped before its last beat");
            check_eq(ram03_wr.we, 0, "residual write without a beat");
        end else begin
            check_eq(round_open, 1, "beat outside a round");
            check_eq({beat2.valid, beat1.valid, beat0.valid}, 3'b001 << exp_ch, "beat channel");
            check_eq(beat_on((exp_ch + 1) % 3), 0, "channel without grant not zero");
            check_eq(beat_on((exp_ch + 2) % 3), 0, "channel without grant not zero");
            if (slice_w == 0) begin
                check_eq(slice_n < rows_of(lay), 1, "more slices than rows in the round");
                check_eq(rdy_hist[3][exp_ch], 1, "slice started while ready was low");
                // ready may drop mid-slice from here on
                rdy_wait[exp_ch] = $urandom_range(0, 60);
            end
            addr = pass * 2 + 8 * (beat_k / 2) + beat_k % 2;
            exp_data = (lay == 1) ? lane_add(mem00[addr], mem02[addr]) : mem01[addr];
            check_eq(b.data.raw, exp_data, "beat data");
            check_eq(b.done, slice_w == mlp_geom_pkg::SLICE_WORDS - 1, "done flag");
            check_eq(ram03_wr.we, lay == 1, "residual write enable");
            if (lay == 1) begin
                check_eq(ram03_wr.addr, addr, "residual write address");
                check_eq(ram03_wr.data.raw, exp_data, "residual write data");
                mem03[ram03_wr.addr] = ram03_wr.data.raw;
                ram03_writes++;
            end
            beat_k++;
            slice_w++;
            if (slice_w == mlp_geom_pkg::SLICE_WORDS) begin
                slice_w = 0;
                slice_n++;
                exp_ch = (exp_ch + 1) % 3;
                if (slice_n == rows_of(lay)) begin
                    fetch_phase = 1'b1;
                    for (int a = 0; a < 3; a++)
                        fin_wait[a] = $urandom_range(0, 20);
                end
            end
        end
    endtask

    task automatic watch_fetch();
        if (psum.valid) begin
            if (sweep_n == 0) begin
                check_eq(fetch_phase && fin_sent[0] && fin_sent[1] && fin_sent[2], 1,
                         "fetch began before all finish pulses");
                check_eq(cyc >= fin_all_at + 2, 1, "fetch began too early after the last finish");
            end
            check_eq(psum.grant, 4'b0001 << (sweep_n / mlp_geom_pkg::UNIT_NUM), "fetch lane grant");
            sweep_n++;
        end else begin
            check_eq(psum.grant, 0, "lane grant outside a fetch");
            if (sweep_n != 0) begin
                check_eq(sweep_n, mlp_geom_pkg::FETCH_BEATS, "fetch length");
                sweep_n = 0;
                fetch_phase = 1'b0;
                round_open = 1'b0;
                for (int a = 0; a < 3; a++)
                    fin_sent[a] = 1'b0;
                col++;
                if (col == cols_of(lay)) begin
                    col = 0;
                    pass++;
                end
                if (pass == mlp_geom_pkg::BASE_PASSES) begin
                    pass = 0;
                    lay++;
                end
            end
        end
    endtask

    // RAMs that the current layer does not read see address zero
    task automatic unused_addr_zero();
        if (lay == 1) begin
            check_eq(ram01_addr, 0, "RAM01 address during FC1");
        end else begin
            check_eq(ram00_addr, 0, "RAM00 address outside FC1");
            check_eq(ram02_addr, 0, "RAM02 address outside FC1");
        end
    endtask

    task automatic clock_step();
        logic [2:0] rdy;
        @(negedge s_clk);
        cyc++;
        // sync read, data of the previous cycle's address
        ram00_dout.raw = mem00[addr00_q];
        ram01_dout.raw = mem01[addr01_q];
        ram02_dout.raw = mem02[addr02_q];
        addr00_q = ram00_addr;
        addr01_q = ram01_addr;
        addr02_q = ram02_addr;
        watch_round();
        watch_beats();
        watch_fetch();
        unused_addr_zero();
        i_finish_calc = '0;
        for (int a = 0; a < 3; a++) begin
            rdy[a] = rdy_wait[a] == 0;
            if (rdy_wait[a] > 0)
                rdy_wait[a]--;
            if (fetch_phase && !fin_sent[a]) begin
                if (fin_wait[a] == 0) begin
                    i_finish_calc[a] = 1'b1;
                    fin_sent[a] = 1'b1;
                    fin_all_at = cyc;
                end else begin
                    fin_wait[a]--;
                end
            end
        end
        i_slice_ready = rdy;
        for (int i = 3; i > 0; i--)
            rdy_hist[i] = rdy_hist[i-1];
        rdy_hist[0] = rdy;
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 20; i++) begin
            clock_step();
            check_eq({beat0.valid, beat0.done, beat1.valid, beat1.done, beat2.valid, beat2.done},
                     0, "beat flags before start");
            check_eq({ram03_wr.we, psum.valid, psum.grant, init_prepare, mlp_done}, 0,
                     "strobes before start");
        end
    endtask

    task automatic run_layer_rounds(input int layer, input int exp_rounds);
        int t;
        t = 0;
        while (lay == layer) begin
            clock_step();
            t++;
            if (t > 5000)
                fail_timeout("layer did not finish its rounds");
        end
        check_eq(layer_rounds[layer], exp_rounds, "rounds in the layer");
    endtask

    task automatic finish_of_run();
        int t;
        t = 0;
        while (done_cnt == 0) begin
            clock_step();
            t++;
            if (t > 100)
                fail_timeout("no done strobe after the last fetch");
        end
        for (int i = 0; i < 30; i++)
            clock_step();
        check_eq(done_cnt, 1, "done strobe count");
        // six FC1 rounds of two slices of eight words
        check_eq(ram03_writes, 96, "residual write count");
        // both passes together cover words 0 to 3 of each 8-word group
        for (int a = 0; a < 64; a++) begin
            if (a % 8 < 4)
                check_eq(mem03[a], lane_add(mem00[a], mem02[a]), "residual RAM contents");
        end
    endtask

    initial begin
        s_clk = 1'b0;
        s_rst = 1'b1;
        i_start = 1'b0;
        i_slice_ready = '0;
        i_finish_calc = '0;
        ram00_dout = '0;
        ram01_dout = '0;
        ram02_dout = '0;
        addr00_q = '0;
        addr01_q = '0;
        addr02_q = '0;
        for (int i = 0; i < 4; i++)
            rdy_hist[i] = '0;
        void'($urandom(32'hcbe4fcc4));
        for (int i = 0; i < 16384; i++)
            mem01[i] = {$urandom, $urandom};
        for (int i = 0; i < 4096; i++) begin
            mem00[i] = {$urandom, $urandom};
            mem02[i] = {$urandom, $urandom};
        end
        for (int a = 0; a < 3; a++)
            rdy_wait[a] = $urandom_range(0, 60);
        for (int i = 0; i < 16; i++)
            @(negedge s_clk);
        s_rst = 1'b0;
        idle_after_reset();
        i_start = 1'b1;
        clock_step();
        i_start = 1'b0;
        run_layer_rounds(0, 4);
        run_layer_rounds(1, 6);
        run_layer_rounds(2, 4);
        finish_of_run();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: vlog.f
rtl/mlp_geom_pkg.sv
rtl/mlp_bus_pkg.sv
rtl/mlp_layer_cfg.sv
rtl/mlp_seq_fsm.sv
rtl/slice_reader.sv
rtl/slice_arbiter.sv
rtl/psum_fetcher.sv
rtl/mlp_top.sv
sim/tb_mlp_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MLP controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mlp_top -f vlog.f -o tb_mlp_top
./obj_dir/tb_mlp_top | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
